//--- verilog.f
+incdir+verilog
verilog/tag_store_pkg.sv
verilog/tag_req_decode.sv
verilog/tag_way_ram.sv
verilog/tag_hit_evict.sv
verilog/tag_result.sv
verilog/tag_store_top.sv
tb/tb_clock_gen.sv
tb/tag_store_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tag store testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tag_store_tb \
  -f verilog.f -o tag_store_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tag_store_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulator exited with an error status"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation result: FAIL"; exit 1; } \
  || { echo "Simulation result: PASS"; exit 0; }

//--- tb/tag_store_tb.sv
// Table-driven testbench for the tag store with one request in flight at a time
// Each response is held back by ready_i for 0 to 3 cycles
// Table expectations are cross-checked against a reference model of the sets
// Locked ways in the table never leave a lookup miss without a victim

`timescale 1ns/100ps
`default_nettype none

`include "tag_store_defs.svh"

module tag_store_tb;

  localparam int NUM_TESTS    = 17;
  localparam int RESET_CYCLES = 4;
  localparam int CLK_PERIOD   = 100;
  localparam int RESP_LIMIT   = 16;
  localparam int NW           = `TS_NUM_WAYS;
  localparam int NSETS        = 1 << `TS_INDEX_W;

  localparam tag_store_pkg::tag_mode_e MODE_LK = tag_store_pkg::TAG_LOOKUP;
  localparam tag_store_pkg::tag_mode_e MODE_FL = tag_store_pkg::TAG_FLUSH;

  // One row of stimulus and expected response
  typedef struct packed {
    tag_store_pkg::tag_mode_e mode;
    tag_store_pkg::index_t    index;
    tag_store_pkg::tag_t      tag;
    logic                     dirty;
    tag_store_pkg::way_ind_t  ind;
    tag_store_pkg::way_ind_t  lock;
    logic                     exp_hit;
    logic                     exp_evict;
    tag_store_pkg::way_ind_t  exp_ind;
    tag_store_pkg::tag_t      exp_etag;
  } test_vec_t;

  logic                      clk_i;
  logic                      rst_n_i;
  // DUT inputs
  logic                      valid_i;
  tag_store_pkg::tag_mode_e  mode_i;
  tag_store_pkg::index_t     index_i;
  tag_store_pkg::tag_t       tag_i;
  logic                      dirty_i;
  tag_store_pkg::way_ind_t   indicator_i;
  tag_store_pkg::way_ind_t   spm_lock_i;
  logic                      ready_i;
  // DUT outputs
  logic                      ready_o;
  logic                      valid_o;
  logic                      res_hit_o;
  logic                      res_evict_o;
  tag_store_pkg::way_ind_t   res_indicator_o;
  tag_store_pkg::tag_t       res_evict_tag_o;

  test_vec_t                 vectors [NUM_TESTS];
  // Reference model of the storage and the replacement pointer
  tag_store_pkg::tag_entry_t model_mem [NW][NSETS];
  int                        model_ptr;
  int                        error_count;
  int                        tests_passed;
  integer                    seed;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  tag_store_top i_dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .spm_lock_i      (spm_lock_i),
    .valid_i         (valid_i),
    .mode_i          (mode_i),
    .index_i         (index_i),
    .tag_i           (tag_i),
    .dirty_i         (dirty_i),
    .indicator_i     (indicator_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_indicator_o (res_indicator_o),
    .res_evict_tag_o (res_evict_tag_o),
    .ready_i         (ready_i)
  );

  // ----------------------------------------------------------------------
  // Compare tasks for each result type
  // ----------------------------------------------------------------------
  task automatic compare_ind(input string what, input tag_store_pkg::way_ind_t got,
                             input tag_store_pkg::way_ind_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_tag(input string what, input tag_store_pkg::tag_t got,
                             input tag_store_pkg::tag_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------
  task automatic set_row(input int n, input tag_store_pkg::tag_mode_e mode,
                         input tag_store_pkg::index_t idx, input tag_store_pkg::tag_t tag,
                         input logic dirty, input tag_store_pkg::way_ind_t ind,
                         input tag_store_pkg::way_ind_t lock, input logic hit,
                         input logic evict, input tag_store_pkg::way_ind_t eind,
                         input tag_store_pkg::tag_t etag);
    vectors[n] = '{mode, idx, tag, dirty, ind, lock, hit, evict, eind, etag};
  endtask

  task automatic load_table();
    // n  mode     set   tag    dirty ind      lock     hit   evict eind     etag
    // Fresh sets miss into way 0
    set_row(0,  MODE_LK, 4'd3,  8'h11, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0001, 8'h00);
    set_row(1,  MODE_LK, 4'd15, 8'hab, 1'b1, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0001, 8'h00);
    // Hit, dirty upgrade, dirty flush, then a miss on the flushed tag
    set_row(2,  MODE_LK, 4'd3,  8'h11, 1'b0, 4'b1111, 4'b0000, 1'b1, 1'b0, 4'b0001, 8'h00);
    set_row(3,  MODE_LK, 4'd3,  8'h11, 1'b1, 4'b1111, 4'b0000, 1'b1, 1'b0, 4'b0001, 8'h00);
    set_row(4,  MODE_FL, 4'd3,  8'h00, 1'b0, 4'b0001, 4'b0000, 1'b0, 1'b1, 4'b0001, 8'h11);
    set_row(5,  MODE_LK, 4'd3,  8'h11, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0001, 8'h00);
    // Fill set 5
    set_row(6,  MODE_LK, 4'd5,  8'h20, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0001, 8'h00);
    set_row(7,  MODE_LK, 4'd5,  8'h21, 1'b1, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0010, 8'h00);
    set_row(8,  MODE_LK, 4'd5,  8'h22, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0100, 8'h00);
    set_row(9,  MODE_LK, 4'd5,  8'h23, 1'b1, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b1000, 8'h00);
    // Round robin eviction with some ways locked
    set_row(10, MODE_LK, 4'd5,  8'h24, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b0001, 8'h20);
    set_row(11, MODE_LK, 4'd5,  8'h25, 1'b1, 4'b1111, 4'b0000, 1'b0, 1'b1, 4'b0010, 8'h21);
    set_row(12, MODE_LK, 4'd5,  8'h26, 1'b0, 4'b1111, 4'b0100, 1'b0, 1'b1, 4'b1000, 8'h23);
    set_row(13, MODE_LK, 4'd5,  8'h27, 1'b0, 4'b1111, 4'b0001, 1'b0, 1'b1, 4'b0010, 8'h25);
    // A lock does not hide a hit
    set_row(14, MODE_LK, 4'd5,  8'h26, 1'b0, 4'b1111, 4'b1000, 1'b1, 1'b0, 4'b1000, 8'h00);
    // Clean flush and a miss of the same tag into the freed way
    set_row(15, MODE_FL, 4'd5,  8'h00, 1'b0, 4'b1000, 4'b0000, 1'b0, 1'b0, 4'b1000, 8'h26);
    set_row(16, MODE_LK, 4'd5,  8'h26, 1'b0, 4'b1111, 4'b0000, 1'b0, 1'b0, 4'b1000, 8'h00);
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  task automatic predict_response(input test_vec_t row, output logic hit,
                                  output logic evict, output tag_store_pkg::way_ind_t ind,
                                  output tag_store_pkg::tag_t etag);
    int                        way;
    int                        cand;
    tag_store_pkg::tag_entry_t ent;
    way   = -1;
    hit   = 1'b0;
    evict = 1'b0;
    ind   = '0;
    etag  = '0;
    if (row.mode == tag_store_pkg::TAG_FLUSH) begin
      for (int w = 0; w < NW; w++) begin
        if (row.ind[w]) begin
          way = w;
        end
      end
      ent   = model_mem[way][row.index];
      ind   = row.ind;
      evict = ent.valid & ent.dirty;
      etag  = ent.tag;
      model_mem[way][row.index] = '0;
    end else begin
      for (int w = 0; w < NW; w++) begin
        ent = model_mem[w][row.index];
        if (row.ind[w] && ent.valid && (ent.tag == row.tag)) begin
          way = w;
        end
      end
      if (way >= 0) begin
        hit = 1'b1;
        ind = tag_store_pkg::way_ind_t'(1) << way;
        if (row.dirty) begin
          model_mem[way][row.index].dirty = 1'b1;
        end
      end else begin
        // Empty ways first and the lowest index wins
        for (int w = 0; w < NW; w++) begin
          ent = model_mem[w][row.index];
          if ((way < 0) && row.ind[w] && !row.lock[w] && !ent.valid) begin
            way = w;
          end
        end
        // Full set walks from the pointer
        if (way < 0) begin
          for (int k = 0; k < NW; k++) begin
            cand = (model_ptr + k) % NW;
            if ((way < 0) && row.ind[cand] && !row.lock[cand]) begin
              way = cand;
            end
          end
          if (way >= 0) begin
            model_ptr = (way + 1) % NW;
          end
        end
        if (way < 0) begin
          $display("Reference model found no way to take the miss");
          error_count++;
        end else begin
          ent       = model_mem[way][row.index];
          ind       = tag_store_pkg::way_ind_t'(1) << way;
          evict     = ent.valid & ent.dirty;
          etag      = ent.tag;
          ent.valid = 1'b1;
          ent.dirty = row.dirty;
          ent.tag   = row.tag;
          model_mem[way][row.index] = ent;
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // One table row through the DUT
  // ----------------------------------------------------------------------
  task automatic run_test(input int n);
    test_vec_t               row;
    logic                    m_hit;
    logic                    m_evict;
    tag_store_pkg::way_ind_t m_ind;
    tag_store_pkg::tag_t     m_etag;
    int                      stall;
    int                      waited;
    int                      errors_before;
    row           = vectors[n];
    errors_before = error_count;
    predict_response(row, m_hit, m_evict, m_ind, m_etag);
    if ((m_hit !== row.exp_hit) || (m_evict !== row.exp_evict) ||
        (m_ind !== row.exp_ind) || (m_etag !== row.exp_etag)) begin
      $display("Test %0d: reference model disagrees with the table entry", n);
      error_count++;
    end
    // Cycles of back-pressure for this response
    stall = $unsigned($random(seed)) % 4;

    @(posedge clk_i);
    valid_i     <= 1'b1;
    mode_i      <= row.mode;
    index_i     <= row.index;
    tag_i       <= row.tag;
    dirty_i     <= row.dirty;
    indicator_i <= row.ind;
    spm_lock_i  <= row.lock;

    // Request handshake
    waited = 0;
    @(negedge clk_i);
    while (!ready_o && (waited < RESP_LIMIT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready_o) begin
      $display("Test %0d: the request was not accepted in time", n);
      error_count++;
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
    // Without a stall the response is taken on its first cycle
    ready_i <= (stall == 0);

    // Wait for the response
    waited = 0;
    @(negedge clk_i);
    while (!valid_o && (waited < RESP_LIMIT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (!valid_o) begin
      $display("Test %0d: no response arrived in time", n);
      error_count++;
    end else begin
      compare_bit("res_hit_o", res_hit_o, row.exp_hit);
      compare_bit("res_evict_o", res_evict_o, row.exp_evict);
      compare_ind("res_indicator_o", res_indicator_o, row.exp_ind);
      compare_tag("res_evict_tag_o", res_evict_tag_o, row.exp_etag);
      compare_bit("ready_o while busy", ready_o, 1'b0);
      if (stall > 0) begin
        // Response must hold under back-pressure
        repeat (stall - 1) begin
          @(negedge clk_i);
          compare_bit("valid_o under back-pressure", valid_o, 1'b1);
          compare_bit("ready_o under back-pressure", ready_o, 1'b0);
          compare_bit("held res_hit_o", res_hit_o, row.exp_hit);
          compare_bit("held res_evict_o", res_evict_o, row.exp_evict);
          compare_ind("held res_indicator_o", res_indicator_o, row.exp_ind);
          compare_tag("held res_evict_tag_o", res_evict_tag_o, row.exp_etag);
        end
        @(posedge clk_i);
        ready_i <= 1'b1;
      end
      @(posedge clk_i);
      ready_i <= 1'b0;
      // Exactly one response per request
      @(negedge clk_i);
      compare_bit("valid_o after handshake", valid_o, 1'b0);
      compare_bit("ready_o after handshake", ready_o, 1'b1);
    end

    if (error_count == errors_before) begin
      tests_passed++;
    end
    $display("Test %0d %s set %0d tag %h stall %0d: %s", n,
             (row.mode == tag_store_pkg::TAG_FLUSH) ? "flush" : "lookup",
             row.index, row.tag, stall, (error_count == errors_before) ? "ok" : "error");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    seed         = 63625;
    error_count  = 0;
    tests_passed = 0;
    model_ptr    = 0;
    valid_i      = 1'b0;
    mode_i       = tag_store_pkg::TAG_LOOKUP;
    index_i      = '0;
    tag_i        = '0;
    dirty_i      = 1'b0;
    indicator_i  = '0;
    spm_lock_i   = '0;
    ready_i      = 1'b0;
    for (int w = 0; w < NW; w++) begin
      for (int s = 0; s < NSETS; s++) begin
        model_mem[w][s] = '0;
      end
    end
    load_table();

    @(posedge rst_n_i);
    @(negedge clk_i);
    compare_bit("ready_o after reset", ready_o, 1'b1);
    compare_bit("valid_o after reset", valid_o, 1'b0);

    for (int n = 0; n < NUM_TESTS; n++) begin
      run_test(n);
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             NUM_TESTS, tests_passed, NUM_TESTS - tests_passed, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog of ten cycles per table row plus reset
  initial begin
    #((NUM_TESTS * 10 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within the watchdog time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Clock and reset source for the tag store testbench
// Reset is active low and is released on a rising edge after RESET_CYCLES

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, 50 percent duty
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/tag_store_top.sv
// Tag store top level, four-way set-associative, one operation in flight
// ready_o is high only while no operation is in flight
// The next request is taken at the earliest one edge after the response

`timescale 1ns/100ps
`default_nettype none

`include "tag_store_defs.svh"

module tag_store_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Scratchpad-locked ways, never evicted
  input  tag_store_pkg::way_ind_t  spm_lock_i,
  // Request channel
  input  logic                     valid_i,
  input  tag_store_pkg::tag_mode_e mode_i,
  input  tag_store_pkg::index_t    index_i,
  input  tag_store_pkg::tag_t      tag_i,
  input  logic                     dirty_i,
  input  tag_store_pkg::way_ind_t  indicator_i,
  output logic                     ready_o,
  // Response channel
  output logic                     valid_o,
  output logic                     res_hit_o,
  output logic                     res_evict_o,
  output tag_store_pkg::way_ind_t  res_indicator_o,
  output tag_store_pkg::tag_t      res_evict_tag_o,
  input  logic                     ready_i
);

  // Held request
  tag_store_pkg::tag_mode_e  req_mode;
  tag_store_pkg::tag_t       req_tag;
  tag_store_pkg::way_ind_t   req_ind;
  // Storage port
  logic                      ram_rd, ram_rdvalid;
  tag_store_pkg::way_ind_t   ram_wmask;
  tag_store_pkg::index_t     ram_index;
  tag_store_pkg::tag_entry_t ram_wdata;
  tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] ram_rdata;
  // Execute results
  tag_store_pkg::way_ind_t   hit, victim;
  tag_store_pkg::tag_entry_t sel_entry;
  logic                      resp_done;

  tag_req_decode i_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .mode_i      (mode_i),
    .index_i     (index_i),
    .tag_i       (tag_i),
    .dirty_i     (dirty_i),
    .indicator_i (indicator_i),
    .hit_i       (hit),
    .victim_i    (victim),
    .sel_entry_i (sel_entry),
    .rdvalid_i   (ram_rdvalid),
    .resp_done_i (resp_done),
    .ready_o     (ready_o),
    .mode_o      (req_mode),
    .tag_o       (req_tag),
    .dirty_o     (),
    .indicator_o (req_ind),
    .rd_o        (ram_rd),
    .wmask_o     (ram_wmask),
    .index_o     (ram_index),
    .wdata_o     (ram_wdata)
  );

  tag_way_ram i_ram (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rd_i      (ram_rd),
    .wmask_i   (ram_wmask),
    .index_i   (ram_index),
    .wdata_i   (ram_wdata),
    .rdata_o   (ram_rdata),
    .rdvalid_o (ram_rdvalid)
  );

  tag_hit_evict i_hit_evict (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rdvalid_i   (ram_rdvalid),
    .mode_i      (req_mode),
    .tag_i       (req_tag),
    .indicator_i (req_ind),
    .spm_lock_i  (spm_lock_i),
    .rdata_i     (ram_rdata),
    .hit_o       (hit),
    .victim_o    (victim),
    .sel_entry_o (sel_entry)
  );

  tag_result i_result (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rdvalid_i       (ram_rdvalid),
    .mode_i          (req_mode),
    .indicator_i     (req_ind),
    .hit_i           (hit),
    .victim_i        (victim),
    .sel_entry_i     (sel_entry),
    .ready_i         (ready_i),
    .valid_o         (valid_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_indicator_o (res_indicator_o),
    .res_evict_tag_o (res_evict_tag_o),
    .resp_done_o     (resp_done)
  );

endmodule

`default_nettype wire

//--- verilog/tag_result.sv
// Result stage, forms the response and holds it in an output register
// Response fields hold while valid_o is high and ready_i is low
// resp_done_o marks the handshake edge

`timescale 1ns/100ps
`default_nettype none

module tag_result (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      rdvalid_i,
  input  tag_store_pkg::tag_mode_e  mode_i,
  input  tag_store_pkg::way_ind_t   indicator_i,
  input  tag_store_pkg::way_ind_t   hit_i,
  input  tag_store_pkg::way_ind_t   victim_i,
  input  tag_store_pkg::tag_entry_t sel_entry_i,
  input  logic                      ready_i,
  output logic                      valid_o,
  output logic                      res_hit_o,
  output logic                      res_evict_o,
  output tag_store_pkg::way_ind_t   res_indicator_o,
  output tag_store_pkg::tag_t       res_evict_tag_o,
  output logic                      resp_done_o
);

  logic                    out_busy_q;
  logic                    hit_d, evict_d;
  tag_store_pkg::way_ind_t ind_d;
  tag_store_pkg::tag_t     evict_tag_d;

  // Flush and miss both report the selected entry
  always_comb begin
    hit_d       = 1'b0;
    ind_d       = indicator_i;
    evict_d     = sel_entry_i.valid & sel_entry_i.dirty;
    evict_tag_d = sel_entry_i.tag;
    if (mode_i == tag_store_pkg::TAG_LOOKUP) begin
      if (|hit_i) begin
        hit_d       = 1'b1;
        ind_d       = hit_i;
        evict_d     = 1'b0;
        evict_tag_d = '0;
      end else begin
        ind_d = victim_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_busy_q <= 1'b0;
    end else if (rdvalid_i) begin
      out_busy_q <= 1'b1;
    end else if (resp_done_o) begin
      out_busy_q <= 1'b0;
    end
  end

  // Output register, loaded once per operation
  always_ff @(posedge clk_i) begin
    if (rdvalid_i) begin
      res_hit_o       <= hit_d;
      res_evict_o     <= evict_d;
      res_indicator_o <= ind_d;
      res_evict_tag_o <= evict_tag_d;
    end
  end

  assign valid_o     = out_busy_q;
  assign resp_done_o = out_busy_q & ready_i;

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=>
      (valid_o && $stable({res_hit_o, res_evict_o, res_indicator_o, res_evict_tag_o})))
    else $error("response changed under back-pressure");

endmodule

`default_nettype wire

//--- verilog/tag_hit_evict.sv
// Execute stage of the tag store
// Tag compare and victim choice are combinational on the read data
// Victim order is lowest invalid eligible way, else round robin from a pointer
// Locked ways are never chosen as victim

`timescale 1ns/100ps
`default_nettype none

`include "tag_store_defs.svh"

module tag_hit_evict (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         rdvalid_i,
  input  tag_store_pkg::tag_mode_e                     mode_i,
  input  tag_store_pkg::tag_t                          tag_i,
  input  tag_store_pkg::way_ind_t                      indicator_i,
  input  tag_store_pkg::way_ind_t                      spm_lock_i,
  input  tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] rdata_i,
  output tag_store_pkg::way_ind_t                      hit_o,
  output tag_store_pkg::way_ind_t                      victim_o,
  output tag_store_pkg::tag_entry_t                    sel_entry_o
);

  localparam int unsigned NumWays = `TS_NUM_WAYS;

  tag_store_pkg::way_bin_t ptr_q;
  tag_store_pkg::way_ind_t eligible, free_elig;
  tag_store_pkg::way_bin_t victim_bin, sel_bin, cand;
  logic                    victim_found, use_ptr;

  // One-hot to binary, lowest set bit of a one-hot vector
  function automatic tag_store_pkg::way_bin_t ind_to_bin(tag_store_pkg::way_ind_t ind);
    tag_store_pkg::way_bin_t bin;
    bin = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (ind[w]) begin
        bin = tag_store_pkg::way_bin_t'(w);
      end
    end
    return bin;
  endfunction

  // ----------------------------------------------------------------------
  // Hit detection and eligibility
  // ----------------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      hit_o[w]     = indicator_i[w] & rdata_i[w].valid & (rdata_i[w].tag == tag_i);
      eligible[w]  = indicator_i[w] & ~spm_lock_i[w];
      free_elig[w] = eligible[w] & ~rdata_i[w].valid;
    end
  end

  // ----------------------------------------------------------------------
  // Victim selection
  // ----------------------------------------------------------------------
  always_comb begin
    victim_bin   = '0;
    victim_found = 1'b0;
    use_ptr      = 1'b0;
    cand         = '0;
    if (|free_elig) begin
      victim_bin   = ind_to_bin(free_elig);
      victim_found = 1'b1;
    end else begin
      // Scan downwards so the smallest offset from the pointer wins
      for (int k = NumWays - 1; k >= 0; k--) begin
        cand = ptr_q + tag_store_pkg::way_bin_t'(k);
        if (eligible[cand]) begin
          victim_bin   = cand;
          victim_found = 1'b1;
          use_ptr      = 1'b1;
        end
      end
    end
  end

  assign victim_o = victim_found ? (tag_store_pkg::way_ind_t'(1) << victim_bin) : '0;

  // Entry of the hit, victim or flushed way
  always_comb begin
    if (mode_i == tag_store_pkg::TAG_FLUSH) begin
      sel_bin = ind_to_bin(indicator_i);
    end else if (|hit_o) begin
      sel_bin = ind_to_bin(hit_o);
    end else begin
      sel_bin = victim_bin;
    end
  end

  assign sel_entry_o = rdata_i[sel_bin];

  // Pointer moves past a round-robin victim only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (rdvalid_i && (mode_i == tag_store_pkg::TAG_LOOKUP) && !(|hit_o) && use_ptr) begin
      ptr_q <= victim_bin + tag_store_pkg::way_bin_t'(1);
    end
  end

  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rdvalid_i |-> $onehot0(hit_o))
    else $error("tag matched in more than one way");

  // A miss needs somewhere to go
  miss_has_way: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rdvalid_i && (mode_i == tag_store_pkg::TAG_LOOKUP) && !(|hit_o)) |-> (|eligible))
    else $error("lookup miss with every indicated way locked");

endmodule

`default_nettype wire

//--- verilog/tag_way_ram.sv
// Tag entry storage, one flip-flop array per way
// All ways are read together, one cycle of read latency
// Resets to all entries invalid

`timescale 1ns/100ps
`default_nettype none

`include "tag_store_defs.svh"

module tag_way_ram (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         rd_i,
  input  tag_store_pkg::way_ind_t                      wmask_i,
  input  tag_store_pkg::index_t                        index_i,
  input  tag_store_pkg::tag_entry_t                    wdata_i,
  output tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] rdata_o,
  output logic                                         rdvalid_o
);

  localparam int unsigned NumWays = `TS_NUM_WAYS;
  localparam int unsigned NumSets = 1 << `TS_INDEX_W;

  tag_store_pkg::tag_entry_t mem_q [NumWays][NumSets];

  // Storage array, per-way write enable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int s = 0; s < NumSets; s++) begin
          mem_q[w][s] <= '0;
        end
      end
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (wmask_i[w]) begin
          mem_q[w][index_i] <= wdata_i;
        end
      end
    end
  end

  // Read port, all ways at one index
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rdata_o[w] <= mem_q[w][index_i];
      end
    end
  end

  // One-cycle valid token per read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdvalid_o <= 1'b0;
    end else begin
      rdvalid_o <= rd_i;
    end
  end

  // Decode never reads and writes in the same cycle
  no_rd_wr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rd_i && (|wmask_i)))
    else $error("storage read and write in the same cycle");

endmodule

`default_nettype wire

//--- verilog/tag_req_decode.sv
// Request decode stage of the tag store
// Holds one request from acceptance until its response is taken
// Request fields must stay stable while valid_i is high
// A flush must name exactly one way

`timescale 1ns/100ps
`default_nettype none

module tag_req_decode (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request channel
  input  logic                      valid_i,
  input  tag_store_pkg::tag_mode_e  mode_i,
  input  tag_store_pkg::index_t     index_i,
  input  tag_store_pkg::tag_t       tag_i,
  input  logic                      dirty_i,
  input  tag_store_pkg::way_ind_t   indicator_i,
  // Execute stage results
  input  tag_store_pkg::way_ind_t   hit_i,
  input  tag_store_pkg::way_ind_t   victim_i,
  input  tag_store_pkg::tag_entry_t sel_entry_i,
  input  logic                      rdvalid_i,
  input  logic                      resp_done_i,
  output logic                      ready_o,
  // Held request
  output tag_store_pkg::tag_mode_e  mode_o,
  output tag_store_pkg::tag_t       tag_o,
  output logic                      dirty_o,
  output tag_store_pkg::way_ind_t   indicator_o,
  // Storage control
  output logic                      rd_o,
  output tag_store_pkg::way_ind_t   wmask_o,
  output tag_store_pkg::index_t     index_o,
  output tag_store_pkg::tag_entry_t wdata_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e state_q, state_d;
  logic   accept;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  assign ready_o = (state_q == ST_IDLE);
  assign accept  = valid_i & ready_o;
  // Storage read goes out the cycle after acceptance, from the held index
  assign rd_o    = (state_q == ST_READ);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (valid_i) state_d = ST_READ;
      ST_READ: state_d = ST_WAIT;
      ST_WAIT: if (rdvalid_i) state_d = ST_RESP;
      ST_RESP: if (resp_done_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request hold registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_o      <= mode_i;
      index_o     <= index_i;
      tag_o       <= tag_i;
      dirty_o     <= dirty_i;
      indicator_o <= indicator_i;
    end
  end

  // ----------------------------------------------------------------------
  // Storage write-back, in the cycle the read data is present
  // ----------------------------------------------------------------------
  always_comb begin
    wmask_o = '0;
    wdata_o = '0;
    if ((state_q == ST_WAIT) && rdvalid_i) begin
      if (mode_o == tag_store_pkg::TAG_FLUSH) begin
        // Clear the flushed entry
        wmask_o = indicator_o;
      end else if (|hit_i) begin
        // Dirty upgrade only for a clean line
        if (dirty_o && !sel_entry_i.dirty) begin
          wmask_o = hit_i;
          wdata_o = tag_store_pkg::tag_entry_t'{valid: 1'b1, dirty: 1'b1, tag: tag_o};
        end
      end else begin
        // Miss, allocate in the victim way
        wmask_o = victim_i;
        wdata_o = tag_store_pkg::tag_entry_t'{valid: 1'b1, dirty: dirty_o, tag: tag_o};
      end
    end
  end

  // Flush targets a single way
  flush_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (accept && (mode_i == tag_store_pkg::TAG_FLUSH)) |-> $onehot(indicator_i))
    else $error("flush accepted without a one-hot way indicator");

endmodule

`default_nettype wire

//--- verilog/tag_store_pkg.sv
// Types shared by all tag store stages
// Widths come from the geometry macros in the defs header
// way_bin_t is sized for 4 ways

`default_nettype none

`include "tag_store_defs.svh"

package tag_store_pkg;

  // One bit per way, used for indicators, hits, victims and locks
  typedef logic [`TS_NUM_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [$clog2(`TS_NUM_WAYS)-1:0] way_bin_t;

  typedef logic [`TS_INDEX_W-1:0] index_t;
  typedef logic [`TS_TAG_W-1:0]   tag_t;

  // Storage word, valid and dirty above the tag
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Operation requested on the channel
  typedef enum logic {
    TAG_LOOKUP = 1'b0,
    TAG_FLUSH  = 1'b1
  } tag_mode_e;

endpackage

`default_nettype wire

//--- verilog/tag_store_defs.svh
// Geometry of the tag store, shared by the package and the RTL
// TS_NUM_WAYS must be a power of two, since the replacement pointer wraps
// by overflow of the binary way number
// The set count is 2**TS_INDEX_W

`ifndef TAG_STORE_DEFS_SVH
`define TAG_STORE_DEFS_SVH

// Associativity
`define TS_NUM_WAYS 4

// Set index width, 16 sets
`define TS_INDEX_W 4

// Stored tag width
`define TS_TAG_W 8

`endif
